//--- rtl/iot_pkg.sv
/* Shared widths, card addresses, timer prescale and bus codes for the I/O test
   subsystem. Each RTL file pulls these in by a wildcard import in its header. */

package iot_pkg;

   //////////////////////////////////////////////////////////////////////
   // Bus geometry
   //////////////////////////////////////////////////////////////////////

   localparam int IO_ADDR_W = 10;                         // I/O space address
   localparam int IO_DATA_W = 16;                         // Data bus width

   localparam logic [IO_DATA_W-1:0] BUS_IDLE_DATA = 16'hFFFF; // Unclaimed read

   //////////////////////////////////////////////////////////////////////
   // Card address map, top of the 3xx page
   //////////////////////////////////////////////////////////////////////

   localparam logic [IO_ADDR_W-1:0] CONST_BASE_ADDR = 10'h3F8; // First constant
   localparam int                   CONST_COUNT     = 5;       // 3F8-3FC
   localparam int                   CONST_IDX_W     = $clog2(CONST_COUNT);

   // Constant readback words, index 0 sits at CONST_BASE_ADDR
   localparam logic [0:CONST_COUNT-1][IO_DATA_W-1:0] CONST_WORDS = {
      16'h1234,
      16'h5678,
      16'h9ABC,
      16'hDEF0,
      16'h4321
   };

   localparam logic [IO_ADDR_W-1:0] MULT_A_ADDR = 10'h3FD; // Operand A, reads product
   localparam logic [IO_ADDR_W-1:0] MULT_B_ADDR = 10'h3FE; // Operand B, reads product
   localparam logic [IO_ADDR_W-1:0] TIMER_ADDR  = 10'h3FF; // Timer count

   // Clock cycles per timer tick, odd so it beats against test loops
   localparam int TIMER_PRESCALE = 7;
   localparam int TIMER_PRE_W    = $clog2(TIMER_PRESCALE);

   //////////////////////////////////////////////////////////////////////
   // Bus cycle codes
   //////////////////////////////////////////////////////////////////////

   typedef enum logic [1:0] {
      OP_IDLE  = 2'd0,    // No cycle on the bus
      OP_READ  = 2'd1,
      OP_WRITE = 2'd2
   } bus_op_e;

   typedef enum logic {
      OWNER_CPU   = 1'b0, // Processor port
      OWNER_PANEL = 1'b1  // Front panel port
   } owner_e;

endpackage

//--- rtl/io_bus_arbiter.sv
/* Round-robin arbiter between the processor and front panel ports. It drives the
   shared I/O bus for one cycle per grant and returns read data to the winner. */

module io_bus_arbiter import iot_pkg::*; (
   input  logic                 nw,           // Bus clock
   input  logic                 reset,
   // Processor port
   input  logic                 cpu_req,      // Held until cpu_gnt
   input  logic                 cpu_we,
   input  logic [IO_ADDR_W-1:0] cpu_addr,
   input  logic [IO_DATA_W-1:0] cpu_wdata,
   output logic                 cpu_gnt,      // One-cycle pulse
   output logic [IO_DATA_W-1:0] cpu_rdata,
   output logic                 cpu_rvalid,   // One cycle after the grant
   output logic                 cpu_skip,     // Qualified by cpu_rvalid
   // Front panel port
   input  logic                 panel_req,
   input  logic                 panel_we,
   input  logic [IO_ADDR_W-1:0] panel_addr,
   input  logic [IO_DATA_W-1:0] panel_wdata,
   output logic                 panel_gnt,
   output logic [IO_DATA_W-1:0] panel_rdata,
   output logic                 panel_rvalid,
   // Card responses that are combinational on the bus fields
   input  logic                 mult_hit,
   input  logic [IO_DATA_W-1:0] mult_rdata,
   input  logic                 mult_skip,
   input  logic                 timer_hit,
   input  logic [IO_DATA_W-1:0] timer_rdata,
   // Shared bus to the cards
   output bus_op_e              bus_op,       // OP_IDLE outside a grant cycle
   output logic [IO_ADDR_W-1:0] bus_addr,
   output logic [IO_DATA_W-1:0] bus_wdata
);

   owner_e               rr_ptr;        // Favored master on a tie
   owner_e               cyc_owner;     // Tag of the cycle on the bus
   logic                 cpu_ok;
   logic                 panel_ok;
   logic                 pick_cpu;
   logic                 pick_panel;
   logic                 rd_cyc;
   logic                 hit_any;
   logic [IO_DATA_W-1:0] merged_rdata;

   //////////////////////////////////////////////////////////////////////
   // Grant selection
   //////////////////////////////////////////////////////////////////////

   // A master granted last cycle still shows its request and is barred
   assign cpu_ok     = cpu_req && !cpu_gnt;
   assign panel_ok   = panel_req && !panel_gnt;
   assign pick_cpu   = cpu_ok && (!panel_ok || rr_ptr == OWNER_CPU);
   assign pick_panel = panel_ok && !pick_cpu;

   always_ff @(posedge nw) begin
      if (reset) begin
         cpu_gnt   <= 1'b0;
         panel_gnt <= 1'b0;
         bus_op    <= OP_IDLE;
         rr_ptr    <= OWNER_CPU;
         cyc_owner <= OWNER_CPU;
      end else begin
         cpu_gnt   <= pick_cpu;
         panel_gnt <= pick_panel;
         if (pick_cpu) begin
            bus_op    <= cpu_we ? OP_WRITE : OP_READ;
            cyc_owner <= OWNER_CPU;
            rr_ptr    <= OWNER_PANEL;                 // Panel wins next tie
         end else if (pick_panel) begin
            bus_op    <= panel_we ? OP_WRITE : OP_READ;
            cyc_owner <= OWNER_PANEL;
            rr_ptr    <= OWNER_CPU;
         end else begin
            bus_op    <= OP_IDLE;
         end
      end
   end

   // Address and data follow the winner and hold while idle
   always_ff @(posedge nw) begin
      if (pick_cpu) begin
         bus_addr  <= cpu_addr;
         bus_wdata <= cpu_wdata;
      end else if (pick_panel) begin
         bus_addr  <= panel_addr;
         bus_wdata <= panel_wdata;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Read return
   //////////////////////////////////////////////////////////////////////

   assign rd_cyc  = (bus_op == OP_READ);
   assign hit_any = mult_hit || timer_hit;

   // Wired-OR of the claiming cards or all ones when nobody answers
   assign merged_rdata = hit_any ?
                         (({IO_DATA_W{mult_hit}} & mult_rdata) |
                          ({IO_DATA_W{timer_hit}} & timer_rdata)) :
                         BUS_IDLE_DATA;

   always_ff @(posedge nw) begin
      if (reset) begin
         cpu_rvalid   <= 1'b0;
         panel_rvalid <= 1'b0;
         cpu_skip     <= 1'b0;
      end else begin
         cpu_rvalid   <= rd_cyc && cyc_owner == OWNER_CPU;
         panel_rvalid <= rd_cyc && cyc_owner == OWNER_PANEL;
         cpu_skip     <= rd_cyc && cyc_owner == OWNER_CPU && mult_skip; // No skip on panel
      end
   end

   always_ff @(posedge nw) begin
      if (rd_cyc && cyc_owner == OWNER_CPU) cpu_rdata <= merged_rdata;
      if (rd_cyc && cyc_owner == OWNER_PANEL) panel_rdata <= merged_rdata;
   end

   //////////////////////////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////////////////////////

   a_one_grant : assert property (@(posedge nw) disable iff (reset)
      !(cpu_gnt && panel_gnt));

   // Card decodes must not overlap
   a_one_card : assert property (@(posedge nw) disable iff (reset)
      !(mult_hit && timer_hit));

endmodule

//--- rtl/mult_card.sv
/* Multiplier and constant readback card at 3F8-3FE. Operands load on bus
   writes; reads return fixed words or the low half of the product. */

module mult_card import iot_pkg::*; (
   input  logic                 nw,
   input  logic                 reset,
   input  bus_op_e              bus_op,
   input  logic [IO_ADDR_W-1:0] bus_addr,
   input  logic [IO_DATA_W-1:0] bus_wdata,
   output logic                 mult_hit,    // Card claims this read
   output logic [IO_DATA_W-1:0] mult_rdata,
   output logic                 mult_skip    // Zero product on a 3FE read
);

   logic [IO_DATA_W-1:0]   op_a;             // Port 3FD
   logic [IO_DATA_W-1:0]   op_b;             // Port 3FE
   logic [IO_DATA_W-1:0]   product;          // Low half only
   logic [IO_ADDR_W-1:0]   offset;           // Distance from 3F8
   logic                   is_const;
   logic                   is_prod;
   logic [CONST_IDX_W-1:0] const_idx;

   //////////////////////////////////////////////////////////////////////
   // Operand ports
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge nw) begin
      if (reset) begin
         op_a <= '0;
         op_b <= '0;
      end else if (bus_op == OP_WRITE) begin
         if (bus_addr == MULT_A_ADDR) op_a <= bus_wdata;
         if (bus_addr == MULT_B_ADDR) op_b <= bus_wdata;
      end
   end

   assign product = op_a * op_b;             // Upper 16 bits dropped

   //////////////////////////////////////////////////////////////////////
   // Read decode
   //////////////////////////////////////////////////////////////////////

   assign offset    = bus_addr - CONST_BASE_ADDR;
   assign is_const  = (bus_addr >= CONST_BASE_ADDR) && (offset < IO_ADDR_W'(CONST_COUNT));
   assign is_prod   = (bus_addr == MULT_A_ADDR) || (bus_addr == MULT_B_ADDR);
   assign const_idx = offset[CONST_IDX_W-1:0];

   always_comb begin
      mult_hit   = 1'b0;
      mult_rdata = '0;
      if (bus_op == OP_READ) begin
         if (is_prod) begin
            mult_hit   = 1'b1;
            mult_rdata = product;            // Same value at both ports
         end else if (is_const) begin
            mult_hit   = 1'b1;
            mult_rdata = CONST_WORDS[const_idx];
         end
      end
   end

   // Skip the next instruction when the product read is zero
   assign mult_skip = (bus_op == OP_READ) && (bus_addr == MULT_B_ADDR) &&
                      (product == '0);

   //////////////////////////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////////////////////////

   a_skip_hit : assert property (@(posedge nw) disable iff (reset)
      mult_skip |-> mult_hit);

endmodule

//--- rtl/irq_timer_card.sv
/* Interval timer card at 3FF. A write loads the count and restarts the
   prescaler; the count falls once per tick and irq holds once it hits zero. */

module irq_timer_card import iot_pkg::*; (
   input  logic                 nw,
   input  logic                 reset,
   input  bus_op_e              bus_op,
   input  logic [IO_ADDR_W-1:0] bus_addr,
   input  logic [IO_DATA_W-1:0] bus_wdata,
   output logic                 timer_hit,
   output logic [IO_DATA_W-1:0] timer_rdata,
   output logic                 irq          // Level, cleared by a write
);

   logic [IO_DATA_W-1:0]   count;            // Ticks left before irq
   logic [TIMER_PRE_W-1:0] pre_cnt;          // Cycles into current tick
   logic                   armed;            // Set by the first write
   logic                   load;
   logic                   tick;

   assign load = (bus_op == OP_WRITE) && (bus_addr == TIMER_ADDR);
   assign tick = armed && (pre_cnt == TIMER_PRE_W'(TIMER_PRESCALE - 1));

   //////////////////////////////////////////////////////////////////////
   // Prescaler
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge nw) begin
      if (reset) begin
         pre_cnt <= '0;
         armed   <= 1'b0;
      end else if (load) begin
         pre_cnt <= '0;                      // Restart the tick phase
         armed   <= 1'b1;
      end else if (tick) begin
         pre_cnt <= '0;
      end else if (armed) begin
         pre_cnt <= pre_cnt + 1'b1;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Count and interrupt
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge nw) begin
      if (reset) begin
         count <= '0;
         irq   <= 1'b0;
      end else if (load) begin
         count <= bus_wdata;
         irq   <= 1'b0;                      // Acknowledge
      end else if (tick) begin
         if (count != '0) count <= count - 1'b1;
         else             irq   <= 1'b1;     // Sticky until next write
      end
   end

   // Count readback
   assign timer_hit   = (bus_op == OP_READ) && (bus_addr == TIMER_ADDR);
   assign timer_rdata = count;

   //////////////////////////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////////////////////////

   // The interrupt only rises on an expired count
   a_irq_zero : assert property (@(posedge nw) disable iff (reset)
      $rose(irq) |-> (count == '0));

endmodule

//--- rtl/io_card_top.sv
/* Debug I/O subsystem top. Processor and front panel ports share one bus
   through the arbiter, with the multiplier and timer cards hung on it. */

module io_card_top import iot_pkg::*; (
   input  logic                 nw,
   input  logic                 reset,
   // Processor port
   input  logic                 cpu_req,
   input  logic                 cpu_we,
   input  logic [IO_ADDR_W-1:0] cpu_addr,
   input  logic [IO_DATA_W-1:0] cpu_wdata,
   output logic                 cpu_gnt,
   output logic [IO_DATA_W-1:0] cpu_rdata,
   output logic                 cpu_rvalid,
   output logic                 cpu_skip,
   // Front panel port
   input  logic                 panel_req,
   input  logic                 panel_we,
   input  logic [IO_ADDR_W-1:0] panel_addr,
   input  logic [IO_DATA_W-1:0] panel_wdata,
   output logic                 panel_gnt,
   output logic [IO_DATA_W-1:0] panel_rdata,
   output logic                 panel_rvalid,
   // Timer interrupt level
   output logic                 irq
);

   bus_op_e              bus_op;        // Shared bus
   logic [IO_ADDR_W-1:0] bus_addr;
   logic [IO_DATA_W-1:0] bus_wdata;
   logic                 mult_hit;      // Card returns
   logic [IO_DATA_W-1:0] mult_rdata;
   logic                 mult_skip;
   logic                 timer_hit;
   logic [IO_DATA_W-1:0] timer_rdata;

   io_bus_arbiter u_arb (
      .nw           (nw),
      .reset        (reset),
      .cpu_req      (cpu_req),
      .cpu_we       (cpu_we),
      .cpu_addr     (cpu_addr),
      .cpu_wdata    (cpu_wdata),
      .cpu_gnt      (cpu_gnt),
      .cpu_rdata    (cpu_rdata),
      .cpu_rvalid   (cpu_rvalid),
      .cpu_skip     (cpu_skip),
      .panel_req    (panel_req),
      .panel_we     (panel_we),
      .panel_addr   (panel_addr),
      .panel_wdata  (panel_wdata),
      .panel_gnt    (panel_gnt),
      .panel_rdata  (panel_rdata),
      .panel_rvalid (panel_rvalid),
      .mult_hit     (mult_hit),
      .mult_rdata   (mult_rdata),
      .mult_skip    (mult_skip),
      .timer_hit    (timer_hit),
      .timer_rdata  (timer_rdata),
      .bus_op       (bus_op),
      .bus_addr     (bus_addr),
      .bus_wdata    (bus_wdata)
   );

   mult_card u_mult (
      .nw         (nw),
      .reset      (reset),
      .bus_op     (bus_op),
      .bus_addr   (bus_addr),
      .bus_wdata  (bus_wdata),
      .mult_hit   (mult_hit),
      .mult_rdata (mult_rdata),
      .mult_skip  (mult_skip)
   );

   irq_timer_card u_timer (
      .nw          (nw),
      .reset       (reset),
      .bus_op      (bus_op),
      .bus_addr    (bus_addr),
      .bus_wdata   (bus_wdata),
      .timer_hit   (timer_hit),
      .timer_rdata (timer_rdata),
      .irq         (irq)
   );

endmodule

//--- sim/io_card_tb.sv
/* Directed testbench for io_card_top. Drives both bus masters through the
   constant, multiplier, timer and shared-bus arbitration cases. */

module io_card_tb import iot_pkg::*; ();

   localparam int N_TESTS   = 5;
   localparam int MAX_TIMER = 20;                // Longest count loaded

   logic                 nw;
   logic                 reset;
   logic                 cpu_req, cpu_we, panel_req, panel_we;
   logic [IO_ADDR_W-1:0] cpu_addr, panel_addr;
   logic [IO_DATA_W-1:0] cpu_wdata, panel_wdata;
   logic                 cpu_gnt, cpu_rvalid, cpu_skip;
   logic                 panel_gnt, panel_rvalid;
   logic [IO_DATA_W-1:0] cpu_rdata, panel_rdata;
   logic                 irq;

   int          errors = 0;
   int          cyc = 0;                         // Edge counter
   int          last_gnt_cyc;
   integer      seed = 32'h4c6c_4e5a;
   logic [15:0] model_a = '0;                    // Operand model in grant order
   logic [15:0] model_b = '0;
   logic        prev_cpu_gnt = 0, prev_panel_gnt = 0;

   io_card_top dut (.*);

   initial begin
      nw = 1'b0;
      forever #10 nw = ~nw;
   end

   always @(posedge nw) cyc <= cyc + 1;

   // Watchdog sized on the test count plus the longest timer wait
   initial begin
      #((N_TESTS * 200 + (MAX_TIMER + 1) * TIMER_PRESCALE) * 20);
      $display("Timeout: simulation did not finish in time");
      $display("STATUS: FAIL");
      $finish;
   end

   // Grant monitor
   always @(posedge nw) begin
      #1;
      if (!reset) begin
         if (cpu_gnt && panel_gnt) begin
            $display("Both masters granted in the same cycle at %0t", $time);
            errors++;
         end
         if ((cpu_gnt && prev_cpu_gnt) || (panel_gnt && prev_panel_gnt)) begin
            $display("Same master granted two cycles in a row at %0t", $time);
            errors++;
         end
      end
      prev_cpu_gnt   = cpu_gnt;
      prev_panel_gnt = panel_gnt;
   end

   task automatic check_value(input string name, input logic [15:0] exp, act);
      if (exp !== act) begin
         $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, act);
         errors++;
      end
   endtask

   ////////////////////////////////////////////////////////////////////
   // Bus transfer tasks entered and left 2 units after an edge
   ////////////////////////////////////////////////////////////////////

   task automatic bus_xfer(input bit panel, input bit we, input logic [9:0] addr,
                           input logic [15:0] wdata, output logic [15:0] rdata,
                           output logic skip, output logic [15:0] exp_prod);
      int n;
      n = 0;
      if (panel) begin
         panel_req   = 1;
         panel_we    = we;
         panel_addr  = addr;
         panel_wdata = wdata;
      end else begin
         cpu_req   = 1;
         cpu_we    = we;
         cpu_addr  = addr;
         cpu_wdata = wdata;
      end
      do begin
         @(posedge nw);
         #1;
         n++;
      end while (!(panel ? panel_gnt : cpu_gnt) && n < 50);
      if (n >= 50) begin
         $display("No grant within 50 cycles for addr %h at %0t", addr, $time);
         errors++;
      end
      last_gnt_cyc = cyc;
      if (we && addr == 10'h3FD) model_a = wdata;
      if (we && addr == 10'h3FE) model_b = wdata;
      exp_prod = 16'((32'(model_a) * 32'(model_b)) & 32'hFFFF);
      #1;
      if (panel) panel_req = 0;
      else       cpu_req   = 0;
      rdata = '0;
      skip  = 0;
      if (!we) begin
         @(posedge nw);
         #1;
         if (!(panel ? panel_rvalid : cpu_rvalid)) begin
            $display("Read of %h got no rvalid at %0t", addr, $time);
            errors++;
         end
         rdata = panel ? panel_rdata : cpu_rdata;
         skip  = panel ? 1'b0 : cpu_skip;
         #1;
      end
   endtask

   task automatic cpu_write(input logic [9:0] addr, input logic [15:0] d);
      logic [15:0] r, e;
      logic s;
      bus_xfer(0, 1, addr, d, r, s, e);
   endtask

   task automatic panel_write(input logic [9:0] addr, input logic [15:0] d);
      logic [15:0] r, e;
      logic s;
      bus_xfer(1, 1, addr, d, r, s, e);
   endtask

   task automatic cpu_read(input logic [9:0] addr, output logic [15:0] r,
                           output logic s, output logic [15:0] e);
      bus_xfer(0, 0, addr, '0, r, s, e);
   endtask

   task automatic panel_read(input logic [9:0] addr, output logic [15:0] r,
                             output logic [15:0] e);
      logic s;
      bus_xfer(1, 0, addr, '0, r, s, e);
   endtask

   task automatic wait_cycle(input int c);
      while (cyc < c) begin
         @(posedge nw);
         #1;
         if (irq !== 1'b0) begin
            $display("[FAIL] t=%0t irq expected 0 got %b", $time, irq);
            errors++;
         end
      end
      #1;
   endtask

   ////////////////////////////////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////////////////////////////////

   task automatic const_readback();
      logic [15:0] words [5] = '{16'h1234, 16'h5678, 16'h9ABC, 16'hDEF0, 16'h4321};
      logic [15:0] r, e;
      logic s;
      for (int i = 0; i < 5; i++) begin
         cpu_read(10'h3F8 + 10'(i), r, s, e);
         check_value("cpu_rdata", words[i], r);
         panel_read(10'h3F8 + 10'(i), r, e);
         check_value("panel_rdata", words[i], r);
      end
      cpu_read(10'h3F0, r, s, e);
      check_value("cpu_rdata", 16'hFFFF, r);     // Nobody claims 3F0
   endtask

   task automatic product_readback();
      logic [15:0] a, b, p, r, e;
      logic s;
      for (int i = 0; i < 5; i++) begin
         a = 16'($random(seed));
         b = (i == 4) ? 16'h0 : 16'($random(seed)); // Last pair forces zero
         p = 16'((32'(a) * 32'(b)) & 32'hFFFF);
         cpu_write(10'h3FD, a);
         cpu_write(10'h3FE, b);
         cpu_read(10'h3FD, r, s, e);
         check_value("cpu_rdata", p, r);
         check_value("cpu_skip", 16'(0), 16'(s));   // No skip at 3FD
         cpu_read(10'h3FE, r, s, e);
         check_value("cpu_rdata", p, r);
         check_value("cpu_skip", 16'(p == 0), 16'(s));
         panel_read(10'h3FE, r, e);
         check_value("panel_rdata", p, r);
      end
   endtask

   task automatic timer_countdown();
      logic [15:0] r, e;
      logic s;
      int w, t;
      cpu_write(10'h3FF, 16'(MAX_TIMER));
      w = last_gnt_cyc + 1;                      // Write lands on this edge
      cpu_read(10'h3FF, r, s, e);
      check_value("cpu_rdata", 16'(MAX_TIMER), r);
      t = w + (MAX_TIMER + 1) * TIMER_PRESCALE;
      wait_cycle(t - 1);
      repeat (2) @(posedge nw);
      #1;
      for (int i = 0; i < 10; i++) begin
         check_value("irq", 16'(1), 16'(irq));
         @(posedge nw);
         #1;
      end
      #1;
   endtask

   task automatic reload_clears_irq();
      int w;
      cpu_write(10'h3FF, 16'd5);
      w = last_gnt_cyc + 1;
      wait_cycle(w);                             // irq cleared by the write
      cpu_write(10'h3FF, 16'd0);
      w = last_gnt_cyc + 1;
      wait_cycle(w + TIMER_PRESCALE - 1);
      repeat (2) @(posedge nw);
      #1;
      check_value("irq", 16'(1), 16'(irq));      // One tick for a zero load
      #1;
   endtask

   task automatic bus_sharing();
      fork
         begin
            logic [15:0] r, e;
            logic s;
            for (int i = 0; i < 4; i++) begin
               cpu_write(10'h3FD, 16'($random(seed)));
               cpu_read(10'h3FD, r, s, e);
               check_value("cpu_rdata", e, r);
            end
         end
         begin
            logic [15:0] r, e;
            for (int i = 0; i < 4; i++) begin
               panel_write(10'h3FE, 16'(i + 3));
               panel_read(10'h3FE, r, e);
               check_value("panel_rdata", e, r);
            end
         end
      join
   endtask

   initial begin
      reset       = 1;
      cpu_req     = 0;
      cpu_we      = 0;
      cpu_addr    = '0;
      cpu_wdata   = '0;
      panel_req   = 0;
      panel_we    = 0;
      panel_addr  = '0;
      panel_wdata = '0;
      repeat (3) @(posedge nw);
      #2 reset = 0;
      const_readback();
      product_readback();
      timer_countdown();
      reload_clears_irq();
      bus_sharing();
      repeat (2) @(posedge nw);
      $display("Run complete, errors: %0d", errors);
      if (errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

//--- flist.f
rtl/iot_pkg.sv
rtl/io_bus_arbiter.sv
rtl/mult_card.sv
rtl/irq_timer_card.sv
rtl/io_card_top.sv
sim/io_card_tb.sv

//--- Makefile
# Verilator build and run for the I/O test subsystem

SRCS = $(shell cat flist.f)

all: run

obj_dir/Vio_card_tb: $(SRCS) flist.f
	verilator --binary --timing --assert -Wall -f flist.f --top-module io_card_tb -Mdir obj_dir

run: obj_dir/Vio_card_tb
	./obj_dir/Vio_card_tb > sim.log 2>&1; cat sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
